// ==== logic/pmp_pkg.sv ====
/* Types that describe PMP region and security configuration
   Imported by the register block, the checker and the top level */
package pmp_pkg;

  // Region and request addresses are byte addresses, word granular
  localparam int unsigned pmp_addr_w = 34;

  // ----------------------------------------------------------
  // Address-match mode, same encoding as the pmpcfg A field
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    pmp_mode_off   = 2'b00,
    pmp_mode_tor   = 2'b01,
    pmp_mode_na4   = 2'b10,
    pmp_mode_napot = 2'b11
  } pmp_mode_e;

  // One pmpcfg byte, lock in bit 7 and read in bit 0
  typedef struct packed {
    logic       lock;
    // Always stored as zero
    logic [1:0] rsvd;
    pmp_mode_e  mode;
    logic       exec;
    logic       write;
    logic       read;
  } pmp_cfg_t;

  // ----------------------------------------------------------
  // Machine security config (Smepmp)
  // ----------------------------------------------------------
  // Bit 0 mml, bit 1 mmwp, bit 2 rlb
  typedef struct packed {
    // Rule locking bypass
    logic rlb;
    // Machine mode whitelist policy, denies unmatched M accesses
    logic mmwp;
    // Machine mode lockdown
    logic mml;
  } pmp_mseccfg_t;

endpackage

// ==== logic/core_pkg.sv ====
/* Core-wide encodings seen by the PMP block
   Privilege level, access type and PMP write opcode */
package core_pkg;

  // RISC-V privilege encodings, 2'b10 is reserved
  typedef enum logic [1:0] {
    priv_lvl_u = 2'b00,
    priv_lvl_s = 2'b01,
    priv_lvl_m = 2'b11
  } priv_lvl_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    pmp_acc_exec  = 2'b00,
    pmp_acc_write = 2'b01,
    pmp_acc_read  = 2'b10
  } pmp_acc_e;

  // ----------------------------------------------------------
  // Opcode on the PMP write port
  // ----------------------------------------------------------
  // Config and address writes target one region by index
  typedef enum logic [1:0] {
    csr_op_wr_cfg     = 2'b00,
    csr_op_wr_addr    = 2'b01,
    csr_op_wr_mseccfg = 2'b10
  } csr_op_e;

endpackage

// ==== logic/pmp_csr_regs.sv ====
/* PMP config, address and mseccfg registers with their write-protection rules
   One strobe applies at most one write, contents are visible to the checker next cycle */
`timescale 1ns/1ps

module pmp_csr_regs #(
  parameter int unsigned num_regions     = 4,
  parameter int unsigned pmp_granularity = 0,
  localparam int unsigned idx_w          = (num_regions > 1) ? $clog2(num_regions) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Write port
  input  logic                           csr_we_i,
  input  core_pkg::csr_op_e              csr_op_i,
  input  logic [idx_w-1:0]               csr_idx_i,
  input  logic [pmp_pkg::pmp_addr_w-1:0] csr_wdata_i,
  // Register contents towards the checker
  output pmp_pkg::pmp_cfg_t              pmp_cfg_o [num_regions],
  output logic [pmp_pkg::pmp_addr_w-1:0] pmp_addr_o [num_regions],
  output pmp_pkg::pmp_mseccfg_t          pmp_mseccfg_o
);

  import pmp_pkg::*;
  import core_pkg::*;

  pmp_cfg_t               cfg_q [num_regions];
  logic [pmp_addr_w-1:0]  addr_q [num_regions];
  pmp_mseccfg_t           mseccfg_q;

  logic                   cfg_we;
  logic                   addr_we;
  logic                   sec_we;
  logic [num_regions-1:0] idx_sel;
  logic [num_regions-1:0] cfg_locked;
  logic [num_regions-1:0] addr_locked;
  logic [num_regions-1:0] cfg_wr;
  logic [num_regions-1:0] addr_wr;
  logic                   any_lock;
  pmp_cfg_t               cfg_wdata;
  logic                   cfg_wr_ok;
  logic [pmp_addr_w-1:0]  addr_wdata;

  // ----------------------------------------------------------
  // Write decode
  // ----------------------------------------------------------
  assign cfg_we  = csr_we_i & (csr_op_i == csr_op_wr_cfg);
  assign addr_we = csr_we_i & (csr_op_i == csr_op_wr_addr);
  assign sec_we  = csr_we_i & (csr_op_i == csr_op_wr_mseccfg);

  // Config byte from the low bits, reserved field forced to zero
  always_comb begin
    cfg_wdata      = pmp_cfg_t'(csr_wdata_i[7:0]);
    cfg_wdata.rsvd = 2'b00;
  end

  // Address kept in word units, byte offset bits read as zero
  assign addr_wdata = {csr_wdata_i[pmp_addr_w-1:2], 2'b00};

  // Content checks on the new config byte
  always_comb begin
    cfg_wr_ok = 1'b1;
    // W without R is reserved unless mml gives it a meaning
    if (!mseccfg_q.mml && cfg_wdata.write && !cfg_wdata.read) begin
      cfg_wr_ok = 1'b0;
    end
    // NA4 cannot be selected once the granule exceeds one word
    if ((pmp_granularity > 0) && (cfg_wdata.mode == pmp_mode_na4)) begin
      cfg_wr_ok = 1'b0;
    end
    // Under mml no new locked X region, except shared ones which all have W set
    if (mseccfg_q.mml && !mseccfg_q.rlb && cfg_wdata.lock && cfg_wdata.exec &&
        !cfg_wdata.write) begin
      cfg_wr_ok = 1'b0;
    end
  end

  // ----------------------------------------------------------
  // Per-region lock state
  // ----------------------------------------------------------
  for (genvar i = 0; i < num_regions; i++) begin : g_lock
    assign idx_sel[i]    = (csr_idx_i == idx_w'(i));
    // rlb lifts every lock
    assign cfg_locked[i] = cfg_q[i].lock & ~mseccfg_q.rlb;
    if (i + 1 < num_regions) begin : g_tor_above
      // A locked TOR region above also freezes this address, its base
      assign addr_locked[i] = cfg_locked[i] |
                              (cfg_locked[i+1] & (cfg_q[i+1].mode == pmp_mode_tor));
    end else begin : g_top
      assign addr_locked[i] = cfg_locked[i];
    end
    assign cfg_wr[i]  = cfg_we & idx_sel[i] & ~cfg_locked[i] & cfg_wr_ok;
    assign addr_wr[i] = addr_we & idx_sel[i] & ~addr_locked[i];
  end

  always_comb begin
    any_lock = 1'b0;
    for (int i = 0; i < num_regions; i++) begin
      any_lock = any_lock | cfg_q[i].lock;
    end
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < num_regions; i++) begin
        cfg_q[i]  <= '0;
        addr_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_regions; i++) begin
        if (cfg_wr[i]) begin
          cfg_q[i] <= cfg_wdata;
        end
        if (addr_wr[i]) begin
          addr_q[i] <= addr_wdata;
        end
      end
    end
  end

  // mml and mmwp are sticky, rlb may only rise while nothing is locked
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mseccfg_q <= '0;
    end else if (sec_we) begin
      mseccfg_q.mml  <= mseccfg_q.mml | csr_wdata_i[0];
      mseccfg_q.mmwp <= mseccfg_q.mmwp | csr_wdata_i[1];
      mseccfg_q.rlb  <= csr_wdata_i[2] & (mseccfg_q.rlb | ~any_lock);
    end
  end

  assign pmp_cfg_o     = cfg_q;
  assign pmp_addr_o    = addr_q;
  assign pmp_mseccfg_o = mseccfg_q;

endmodule

// ==== logic/pmp_checker.sv ====
/* PMP access checker, one request per channel per cycle
   Matches against all regions and registers the verdict for the next cycle */
`timescale 1ns/1ps

module pmp_checker #(
  parameter int unsigned num_regions     = 4,
  parameter int unsigned num_chan        = 2,
  parameter int unsigned pmp_granularity = 0
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Register contents
  input  pmp_pkg::pmp_cfg_t              pmp_cfg_i [num_regions],
  input  logic [pmp_pkg::pmp_addr_w-1:0] pmp_addr_i [num_regions],
  input  pmp_pkg::pmp_mseccfg_t          pmp_mseccfg_i,
  // Request channels
  input  logic [num_chan-1:0]            req_valid_i,
  input  core_pkg::priv_lvl_e            req_priv_i [num_chan],
  input  logic [pmp_pkg::pmp_addr_w-1:0] req_addr_i [num_chan],
  input  core_pkg::pmp_acc_e             req_type_i [num_chan],
  // Registered responses
  output logic [num_chan-1:0]            resp_valid_o,
  output logic [num_chan-1:0]            resp_err_o
);

  import pmp_pkg::*;
  import core_pkg::*;

  // Lowest address bit that takes part in a compare
  localparam int unsigned cmp_lsb = pmp_granularity + 2;

  logic [pmp_addr_w-1:0]                  start_addr [num_regions];
  logic [pmp_addr_w-1:cmp_lsb]            addr_mask  [num_regions];
  logic [num_chan-1:0][num_regions-1:0]   region_match;
  logic [num_chan-1:0][num_regions-1:0]   perm_orig;
  logic [num_chan-1:0][num_regions-1:0]   perm_mml;
  logic [num_chan-1:0]                    access_fault;

  // ----------------------------------------------------------
  // Per-region base address and NAPOT mask
  // ----------------------------------------------------------
  for (genvar r = 0; r < num_regions; r++) begin : g_region
    logic region_napot;
    assign region_napot = (pmp_cfg_i[r].mode == pmp_mode_napot);

    // TOR starts at the previous address, region 0 at zero
    if (r == 0) begin : g_first
      assign start_addr[r] = (pmp_cfg_i[r].mode == pmp_mode_tor) ? '0 : pmp_addr_i[r];
    end else begin : g_rest
      assign start_addr[r] = (pmp_cfg_i[r].mode == pmp_mode_tor) ? pmp_addr_i[r-1] :
                                                                    pmp_addr_i[r];
    end

    // A bit is compared unless every bit below it is a trailing one
    for (genvar b = cmp_lsb; b < pmp_addr_w; b++) begin : g_mask
      if (b == 2) begin : g_bit2
        // NAPOT covers at least 8 bytes
        assign addr_mask[r][b] = ~region_napot;
      end else if (pmp_granularity == 0) begin : g_fine
        assign addr_mask[r][b] = ~region_napot | ~&pmp_addr_i[r][b-1:2];
      end else begin : g_coarse
        // Bits below the granule already read as ones
        assign addr_mask[r][b] = ~region_napot | ~&pmp_addr_i[r][b-1:pmp_granularity+1];
      end
    end
  end

  // ----------------------------------------------------------
  // Per channel: match, permissions, priority
  // ----------------------------------------------------------
  for (genvar c = 0; c < num_chan; c++) begin : g_chan
    logic [pmp_addr_w-1:cmp_lsb] req_word;
    logic                        fault;

    assign req_word = req_addr_i[c][pmp_addr_w-1:cmp_lsb];

    for (genvar r = 0; r < num_regions; r++) begin : g_check
      logic     hit_eq;
      logic     hit_ge;
      logic     hit_lt;
      logic     region_hit;
      logic     basic_ok;
      logic     mml_ok;
      pmp_cfg_t cfg;

      assign cfg    = pmp_cfg_i[r];
      assign hit_eq = ((req_word ^ start_addr[r][pmp_addr_w-1:cmp_lsb]) & addr_mask[r]) == '0;
      assign hit_ge = req_word >= start_addr[r][pmp_addr_w-1:cmp_lsb];
      // Top of range itself is excluded
      assign hit_lt = req_word < pmp_addr_i[r][pmp_addr_w-1:cmp_lsb];

      always_comb begin
        unique case (cfg.mode)
          pmp_mode_na4, pmp_mode_napot: region_hit = hit_eq;
          pmp_mode_tor:                 region_hit = hit_ge & hit_lt;
          default:                      region_hit = 1'b0;
        endcase
      end

      // Permission bit for the requested access type
      assign basic_ok = ((req_type_i[c] == pmp_acc_exec)  & cfg.exec)  |
                        ((req_type_i[c] == pmp_acc_write) & cfg.write) |
                        ((req_type_i[c] == pmp_acc_read)  & cfg.read);

      // Smepmp table
      always_comb begin
        mml_ok = 1'b0;
        if (!cfg.read && cfg.write) begin
          // Shared encodings, selected by lock and exec
          unique case ({cfg.lock, cfg.exec})
            2'b00: mml_ok = (req_type_i[c] == pmp_acc_read) |
                            ((req_type_i[c] == pmp_acc_write) & (req_priv_i[c] == priv_lvl_m));
            2'b01: mml_ok = (req_type_i[c] == pmp_acc_read) |
                            (req_type_i[c] == pmp_acc_write);
            2'b10: mml_ok = (req_type_i[c] == pmp_acc_exec);
            default: mml_ok = (req_type_i[c] == pmp_acc_exec) |
                              ((req_type_i[c] == pmp_acc_read) & (req_priv_i[c] == priv_lvl_m));
          endcase
        end else if (cfg.read && cfg.write && cfg.exec && cfg.lock) begin
          // Locked RWX is read only for everyone
          mml_ok = (req_type_i[c] == pmp_acc_read);
        end else if (req_priv_i[c] == priv_lvl_m) begin
          // Locked rules bind M only
          mml_ok = cfg.lock & basic_ok;
        end else begin
          // Unlocked rules bind S and U only
          mml_ok = ~cfg.lock & basic_ok;
        end
      end

      assign region_match[c][r] = region_hit;
      // M passes unlocked regions
      assign perm_orig[c][r] = (req_priv_i[c] == priv_lvl_m) ? (~cfg.lock | basic_ok) : basic_ok;
      assign perm_mml[c][r]  = mml_ok;
    end

    // Default when nothing matches, then the lowest region wins
    always_comb begin
      fault = pmp_mseccfg_i.mmwp | (req_priv_i[c] != priv_lvl_m);
      for (int r = int'(num_regions) - 1; r >= 0; r--) begin
        if (region_match[c][r]) begin
          fault = pmp_mseccfg_i.mml ? ~perm_mml[c][r] : ~perm_orig[c][r];
        end
      end
    end

    assign access_fault[c] = fault;
  end

  // ----------------------------------------------------------
  // Response stage
  // ----------------------------------------------------------
  // err only rises together with valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= '0;
      resp_err_o   <= '0;
    end else begin
      resp_valid_o <= req_valid_i;
      resp_err_o   <= req_valid_i & access_fault;
    end
  end

endmodule

// ==== logic/pmp_unit.sv ====
/* PMP top level, register block feeding the access checker
   Outside ports are plain per-channel arrays */
`timescale 1ns/1ps

module pmp_unit #(
  parameter int unsigned num_regions     = 4,
  parameter int unsigned num_chan        = 2,
  parameter int unsigned pmp_granularity = 0,
  localparam int unsigned idx_w          = (num_regions > 1) ? $clog2(num_regions) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Configuration write port
  input  logic                           csr_we_i,
  input  core_pkg::csr_op_e              csr_op_i,
  input  logic [idx_w-1:0]               csr_idx_i,
  input  logic [pmp_pkg::pmp_addr_w-1:0] csr_wdata_i,
  // Request channels
  input  logic [num_chan-1:0]            req_valid_i,
  input  core_pkg::priv_lvl_e            req_priv_i [num_chan],
  input  logic [pmp_pkg::pmp_addr_w-1:0] req_addr_i [num_chan],
  input  core_pkg::pmp_acc_e             req_type_i [num_chan],
  // Responses, one cycle after the request
  output logic [num_chan-1:0]            resp_valid_o,
  output logic [num_chan-1:0]            resp_err_o
);

  import pmp_pkg::*;

  // Register outputs towards the checker
  pmp_cfg_t              pmp_cfg     [num_regions];
  logic [pmp_addr_w-1:0] pmp_addr    [num_regions];
  pmp_mseccfg_t          pmp_mseccfg;

  // ----------------------------------------------------------
  // Register block
  // ----------------------------------------------------------
  pmp_csr_regs #(
    .num_regions     (num_regions),
    .pmp_granularity (pmp_granularity)
  ) i_pmp_csr_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .csr_we_i      (csr_we_i),
    .csr_op_i      (csr_op_i),
    .csr_idx_i     (csr_idx_i),
    .csr_wdata_i   (csr_wdata_i),
    .pmp_cfg_o     (pmp_cfg),
    .pmp_addr_o    (pmp_addr),
    .pmp_mseccfg_o (pmp_mseccfg)
  );

  // ----------------------------------------------------------
  // Access checker
  // ----------------------------------------------------------
  pmp_checker #(
    .num_regions     (num_regions),
    .num_chan        (num_chan),
    .pmp_granularity (pmp_granularity)
  ) i_pmp_checker (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .pmp_cfg_i     (pmp_cfg),
    .pmp_addr_i    (pmp_addr),
    .pmp_mseccfg_i (pmp_mseccfg),
    .req_valid_i   (req_valid_i),
    .req_priv_i    (req_priv_i),
    .req_addr_i    (req_addr_i),
    .req_type_i    (req_type_i),
    .resp_valid_o  (resp_valid_o),
    .resp_err_o    (resp_err_o)
  );

endmodule

// ==== verif/pmp_unit_properties.sv ====
/* Timing and reset properties of the PMP unit response channels
   Attached to every pmp_unit instance with bind */
`timescale 1ns/1ps

module pmp_unit_properties #(
  parameter int unsigned num_chan = 2
) (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic [num_chan-1:0] req_valid_i,
  input logic [num_chan-1:0] resp_valid_o,
  input logic [num_chan-1:0] resp_err_o
);

  // ----------------------------------------------------------
  // Per-channel response timing
  // ----------------------------------------------------------
  for (genvar c = 0; c < num_chan; c++) begin : g_chan
    // Every request is answered on the next cycle
    a_resp_follows_req : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      req_valid_i[c] |=> resp_valid_o[c]
    ) else $error("response missing one cycle after request on channel %0d", c);

    // And no response without a request one cycle earlier
    a_resp_needs_req : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      resp_valid_o[c] |-> $past(req_valid_i[c])
    ) else $error("response without request on channel %0d", c);

    // err is qualified by valid
    a_err_needs_valid : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !resp_valid_o[c] |-> !resp_err_o[c]
    ) else $error("resp_err_o high without resp_valid_o on channel %0d", c);
  end

  // ----------------------------------------------------------
  // Reset
  // ----------------------------------------------------------
  a_quiet_in_reset : assert property (
    @(posedge clk_i)
    !rst_n_i |-> (resp_valid_o == '0) && (resp_err_o == '0)
  ) else $error("outputs not low during reset");

endmodule

bind pmp_unit pmp_unit_properties #(
  .num_chan (num_chan)
) i_pmp_unit_properties (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_valid_i  (req_valid_i),
  .resp_valid_o (resp_valid_o),
  .resp_err_o   (resp_err_o)
);

// ==== verif/pmp_unit_tb.sv ====
/* Testbench for pmp_unit with default parameters
   Keeps a model of the PMP registers and checks every verdict against it */
`timescale 1ns/1ps

module pmp_unit_tb;

  import pmp_pkg::*;
  import core_pkg::*;

  localparam int unsigned nreg = 4;
  localparam int unsigned nch  = 2;

  logic             clk_i;
  logic             rst_n_i;
  logic             csr_we_i;
  csr_op_e          csr_op_i;
  logic [1:0]       csr_idx_i;
  logic [33:0]      csr_wdata_i;
  logic [nch-1:0]   req_valid_i;
  priv_lvl_e        req_priv_i [nch];
  logic [33:0]      req_addr_i [nch];
  pmp_acc_e         req_type_i [nch];
  logic [nch-1:0]   resp_valid_o;
  logic [nch-1:0]   resp_err_o;

  // Model of the register state
  pmp_cfg_t         m_cfg [nreg];
  logic [33:0]      m_addr [nreg];
  logic             m_mml;
  logic             m_mmwp;
  logic             m_rlb;

  int               errors;
  int               tests_ok;
  int               tests_bad;
  int               err_mark;
  logic             exp_q [nch];

  pmp_unit i_pmp_unit (.*);

  always #5 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic logic napot_hit(logic [33:0] base, logic [33:0] a);
    int ones;
    int sh;
    ones = 0;
    while (ones < 32 && base[2+ones]) ones++;
    sh = ones + 3;
    if (sh >= 34) return 1'b1;
    return (a >> sh) == (base >> sh);
  endfunction

  function automatic logic region_hit(int r, logic [33:0] a);
    logic [33:0] lo;
    lo = (r == 0) ? 34'h0 : m_addr[r-1];
    case (m_cfg[r].mode)
      pmp_mode_na4:   return a[33:2] == m_addr[r][33:2];
      pmp_mode_napot: return napot_hit(m_addr[r], a);
      pmp_mode_tor:   return (a[33:2] >= lo[33:2]) && (a[33:2] < m_addr[r][33:2]);
      default:        return 1'b0;
    endcase
  endfunction

  function automatic logic region_allows(pmp_cfg_t c, priv_lvl_e p, pmp_acc_e t);
    logic pbit;
    logic is_m;
    logic rd;
    logic wr;
    logic ex;
    is_m = (p == priv_lvl_m);
    rd   = (t == pmp_acc_read);
    wr   = (t == pmp_acc_write);
    ex   = (t == pmp_acc_exec);
    pbit = rd ? c.read : (wr ? c.write : c.exec);
    if (!m_mml) return (is_m && !c.lock) || pbit;
    // Shared encodings first, as {L,R,W,X}
    case ({c.lock, c.read, c.write, c.exec})
      4'b0010: return rd || (wr && is_m);
      4'b0011: return rd || wr;
      4'b1010: return ex;
      4'b1011: return ex || (rd && is_m);
      4'b1111: return rd;
      default: return (c.lock == is_m) && pbit;
    endcase
  endfunction

  function automatic logic expected_err(priv_lvl_e p, logic [33:0] a, pmp_acc_e t);
    for (int r = 0; r < nreg; r++) begin
      if (region_hit(r, a)) return !region_allows(m_cfg[r], p, t);
    end
    return m_mmwp || (p != priv_lvl_m);
  endfunction

  // Apply one write to the model with the protection rules
  function automatic void model_write(csr_op_e op, int idx, logic [33:0] d);
    pmp_cfg_t nc;
    logic     locked;
    logic     any_lock;
    nc       = pmp_cfg_t'(d[7:0]);
    nc.rsvd  = 2'b00;
    locked   = m_cfg[idx].lock && !m_rlb;
    any_lock = 1'b0;
    for (int r = 0; r < nreg; r++) any_lock = any_lock | m_cfg[r].lock;
    if (op == csr_op_wr_cfg) begin
      if (!locked && !(!m_mml && nc.write && !nc.read) &&
          !(m_mml && !m_rlb && nc.lock && nc.exec && !nc.write)) m_cfg[idx] = nc;
    end else if (op == csr_op_wr_addr) begin
      if (idx + 1 < nreg && m_cfg[idx+1].lock && !m_rlb && m_cfg[idx+1].mode == pmp_mode_tor)
        locked = 1'b1;
      if (!locked) m_addr[idx] = {d[33:2], 2'b00};
    end else begin
      m_mml  = m_mml | d[0];
      m_mmwp = m_mmwp | d[1];
      m_rlb  = d[2] && (m_rlb || !any_lock);
    end
  endfunction

  // ----------------------------------------------------------
  // Stimulus tasks, called 1 ns after a rising edge
  // ----------------------------------------------------------
  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    for (int r = 0; r < nreg; r++) begin
      m_cfg[r]  = '0;
      m_addr[r] = '0;
    end
    {m_mml, m_mmwp, m_rlb} = 3'b000;
  endtask

  task automatic csr_write(csr_op_e op, int idx, logic [33:0] d);
    csr_we_i    = 1'b1;
    csr_op_i    = op;
    csr_idx_i   = 2'(idx);
    csr_wdata_i = d;
    model_write(op, idx, d);
    @(posedge clk_i);
    #1 csr_we_i = 1'b0;
  endtask

  // Same request on both channels, then wait for the responses
  task automatic check_access(priv_lvl_e p, logic [33:0] a, pmp_acc_e t);
    int wait_cnt;
    logic exp;
    exp = expected_err(p, a, t);
    req_valid_i = '1;
    for (int c = 0; c < nch; c++) begin
      req_priv_i[c] = p;
      req_addr_i[c] = a;
      req_type_i[c] = t;
    end
    wait_cnt = 0;
    do begin
      @(posedge clk_i);
      #1 req_valid_i = '0;
      wait_cnt++;
    end while (resp_valid_o != '1 && wait_cnt < 8);
    if (resp_valid_o != '1) begin
      $display("Timeout waiting for resp_valid_o at addr %h", a);
      errors++;
    end else begin
      for (int c = 0; c < nch; c++) begin
        assert (resp_err_o[c] == exp) else begin
          $display("Error: resp_err_o[%0d] addr %h expected %h actual %h", c, a, exp,
                   resp_err_o[c]);
          errors++;
        end
      end
    end
  endtask

  task automatic sweep_all(logic [33:0] a);
    check_access(priv_lvl_u, a, pmp_acc_read);
    check_access(priv_lvl_u, a, pmp_acc_write);
    check_access(priv_lvl_u, a, pmp_acc_exec);
    check_access(priv_lvl_s, a, pmp_acc_read);
    check_access(priv_lvl_s, a, pmp_acc_write);
    check_access(priv_lvl_s, a, pmp_acc_exec);
    check_access(priv_lvl_m, a, pmp_acc_read);
    check_access(priv_lvl_m, a, pmp_acc_write);
    check_access(priv_lvl_m, a, pmp_acc_exec);
  endtask

  task automatic end_test(string name);
    if (errors == err_mark) begin
      tests_ok++;
      $display("%s: passed", name);
    end else begin
      tests_bad++;
      $display("%s: failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  function automatic priv_lvl_e rand_priv();
    case ($urandom % 3)
      0:       return priv_lvl_u;
      1:       return priv_lvl_s;
      default: return priv_lvl_m;
    endcase
  endfunction

  function automatic pmp_acc_e rand_acc();
    case ($urandom % 3)
      0:       return pmp_acc_exec;
      1:       return pmp_acc_write;
      default: return pmp_acc_read;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(32'hae37_461b));
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    csr_we_i = 1'b0;
    csr_op_i = csr_op_wr_cfg;
    csr_idx_i = '0;
    csr_wdata_i = '0;
    req_valid_i = '0;
    for (int c = 0; c < nch; c++) begin
      req_priv_i[c] = priv_lvl_m;
      req_addr_i[c] = '0;
      req_type_i[c] = pmp_acc_read;
    end
    errors = 0;
    tests_ok = 0;
    tests_bad = 0;
    err_mark = 0;

    // No regions, default verdicts and idle outputs
    apply_reset();
    for (int i = 0; i < 6; i++) begin
      @(posedge clk_i);
      #1 assert (resp_valid_o == '0) else begin
        $display("Error: resp_valid_o expected %h actual %h", 2'b00, resp_valid_o);
        errors++;
      end
    end
    sweep_all(34'h0_0000_1000);
    end_test("reset defaults");

    // Overlapping regions, R0 NA4, R1 TOR up to 0x1c0, R2 NAPOT 0x180..0x1ff
    apply_reset();
    csr_write(csr_op_wr_addr, 0, 34'h100);
    csr_write(csr_op_wr_addr, 1, 34'h1c0);
    csr_write(csr_op_wr_addr, 2, 34'h1bc);
    csr_write(csr_op_wr_cfg, 0, 34'h11);
    csr_write(csr_op_wr_cfg, 1, 34'h0b);
    csr_write(csr_op_wr_cfg, 2, 34'h1c);
    sweep_all(34'h0fc);
    sweep_all(34'h100);
    sweep_all(34'h104);
    sweep_all(34'h17c);
    sweep_all(34'h180);
    sweep_all(34'h1bc);
    sweep_all(34'h1c0);
    sweep_all(34'h1fc);
    sweep_all(34'h200);
    end_test("region matching");

    // Locked TOR region and its base, unlocked NA4 bypassed by M
    apply_reset();
    csr_write(csr_op_wr_addr, 0, 34'h400);
    csr_write(csr_op_wr_addr, 1, 34'h800);
    csr_write(csr_op_wr_addr, 2, 34'h900);
    csr_write(csr_op_wr_cfg, 1, 34'h89);
    csr_write(csr_op_wr_cfg, 2, 34'h11);
    csr_write(csr_op_wr_cfg, 1, 34'h0f);
    csr_write(csr_op_wr_addr, 0, 34'h000);
    csr_write(csr_op_wr_addr, 1, 34'hc00);
    sweep_all(34'h3fc);
    sweep_all(34'h400);
    sweep_all(34'h7fc);
    sweep_all(34'h900);
    end_test("locking");

    // Smepmp shared encodings, sticky mml and mmwp
    apply_reset();
    csr_write(csr_op_wr_mseccfg, 0, 34'h1);
    for (int r = 0; r < nreg; r++) csr_write(csr_op_wr_addr, r, 34'h1000 + 34'(r * 16));
    csr_write(csr_op_wr_cfg, 0, 34'h12);
    csr_write(csr_op_wr_cfg, 1, 34'h16);
    csr_write(csr_op_wr_cfg, 2, 34'h92);
    csr_write(csr_op_wr_cfg, 3, 34'h96);
    for (int r = 0; r < nreg; r++) sweep_all(34'h1000 + 34'(r * 16));
    csr_write(csr_op_wr_cfg, 0, 34'h9f);
    csr_write(csr_op_wr_mseccfg, 0, 34'h0);
    sweep_all(34'h1000);
    sweep_all(34'h2000);
    csr_write(csr_op_wr_mseccfg, 0, 34'h2);
    csr_write(csr_op_wr_mseccfg, 0, 34'h0);
    sweep_all(34'h2000);
    sweep_all(34'h1010);
    end_test("mml encodings");

    // Rule locking bypass
    apply_reset();
    csr_write(csr_op_wr_mseccfg, 0, 34'h4);
    csr_write(csr_op_wr_addr, 0, 34'h2ffc);
    csr_write(csr_op_wr_cfg, 0, 34'h99);
    csr_write(csr_op_wr_cfg, 0, 34'h9b);
    csr_write(csr_op_wr_addr, 0, 34'h23fc);
    sweep_all(34'h2000);
    csr_write(csr_op_wr_mseccfg, 0, 34'h0);
    csr_write(csr_op_wr_mseccfg, 0, 34'h4);
    csr_write(csr_op_wr_cfg, 0, 34'h9c);
    sweep_all(34'h2000);
    sweep_all(34'h2800);
    end_test("rule locking bypass");

    // Random configuration, both channels every cycle
    apply_reset();
    for (int i = 0; i < 16; i++) begin
      case ($urandom % 5)
        0:       csr_write(csr_op_wr_mseccfg, 0, 34'($urandom % 8));
        1, 2:    csr_write(csr_op_wr_cfg, $urandom % nreg, 34'($urandom % 256));
        default: csr_write(csr_op_wr_addr, $urandom % nreg, 34'($urandom % 1024));
      endcase
    end
    for (int i = 0; i <= 200; i++) begin
      if (i > 0) begin
        for (int c = 0; c < nch; c++) begin
          assert (resp_valid_o[c] && resp_err_o[c] == exp_q[c]) else begin
            $display("Error: resp_err_o[%0d] cycle %0d expected %h actual %h valid %h",
                     c, i, exp_q[c], resp_err_o[c], resp_valid_o[c]);
            errors++;
          end
        end
      end
      req_valid_i = (i < 200) ? '1 : '0;
      for (int c = 0; c < nch; c++) begin
        req_priv_i[c] = rand_priv();
        req_addr_i[c] = 34'($urandom % 1024);
        req_type_i[c] = rand_acc();
        exp_q[c] = expected_err(req_priv_i[c], req_addr_i[c], req_type_i[c]);
      end
      @(posedge clk_i);
      #1;
    end
    end_test("random traffic");

    $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/pmp_pkg.sv
logic/core_pkg.sv
logic/pmp_csr_regs.sv
logic/pmp_checker.sv
logic/pmp_unit.sv
verif/pmp_unit_properties.sv
verif/pmp_unit_tb.sv

// ==== Makefile ====
# Verilator build for the PMP unit and its testbench

VERILATOR ?= verilator
TOP       ?= pmp_unit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
